// ==== logic/soc_defines.svh ====
//////////////////////////////
// Widths and memory map of the system bus
// The address is 32 bits, so every window must end at or below 4 GiB
//////////////////////////////

`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define SOC_ADDR_W     32
`define SOC_DATA_W     64
`define SOC_APB_DATA_W 32

// Backed L2 words, the DRAM window aliases onto them
`define SOC_L2_WORDS 1024

//////////////////////////////
// Memory map
//////////////////////////////

`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LEN  32'h4000_0000
`define SOC_UART_BASE 32'hC000_0000
`define SOC_UART_LEN  32'h0000_1000
`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LEN  32'h0000_1000

// Control register offsets
`define SOC_CTRL_EXIT      12'h000
`define SOC_CTRL_DRAM_BASE 12'h008
`define SOC_CTRL_DRAM_END  12'h010
`define SOC_CTRL_CNT_EN    12'h018

`endif

// ==== logic/soc_pkg.sv ====
//////////////////////////////
// Bus types shared by every stage and target
//////////////////////////////

`default_nettype none

`include "soc_defines.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0]             addr_t;
  typedef logic [`SOC_DATA_W-1:0]             data_t;
  typedef logic [`SOC_DATA_W/8-1:0]           strb_t;
  typedef logic [`SOC_APB_DATA_W-1:0]         apb_data_t;
  typedef logic [$clog2(`SOC_L2_WORDS)-1:0]   l2_idx_t;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

  //////////////////////////////
  // Request and response
  //////////////////////////////

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Byte-enable write merge used by L2 and the control registers
  function automatic data_t strb_merge(data_t old_w, data_t new_w, strb_t strb);
    data_t res;
    res = old_w;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== logic/soc_decode_stage.sv ====
//////////////////////////////
// Two register stages between acceptance and the target strobes
// Only one UART access at a time, ready_o is low while it runs
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module soc_decode_stage import soc_pkg::*; (
  input  wire       clk_i,
  input  wire       rst_i,
  input  wire       req_valid_i,
  input  bus_req_t  req_i,
  output logic      ready_o,
  input  wire       apb_done_i,
  output logic      l2_sel_o,
  output logic      ctrl_sel_o,
  output logic      uart_sel_o,
  output logic      none_sel_o,
  output bus_req_t  stage_req_o
);

  typedef struct packed {
    logic l2;
    logic ctrl;
    logic uart;
    logic none;
  } tgt_t;

  function automatic logic in_win(addr_t addr, addr_t base, addr_t len);
    return (addr - base) < len;
  endfunction

  logic     accept;
  tgt_t     hit;
  tgt_t     tgt_q;
  tgt_t     sel_q;
  bus_req_t req_q;
  bus_req_t stage_req_q;
  logic     uart_pend_q;

  assign accept = req_valid_i && ready_o;

  always_comb begin
    hit.l2   = in_win(req_i.addr, `SOC_DRAM_BASE, `SOC_DRAM_LEN);
    hit.uart = in_win(req_i.addr, `SOC_UART_BASE, `SOC_UART_LEN);
    hit.ctrl = in_win(req_i.addr, `SOC_CTRL_BASE, `SOC_CTRL_LEN);
    hit.none = !(hit.l2 || hit.uart || hit.ctrl);
  end

  //////////////////////////////
  // Pipeline registers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tgt_q <= '0;
      sel_q <= '0;
    end else begin
      tgt_q <= accept ? hit : '0;
      sel_q <= tgt_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    stage_req_q <= req_q;
  end

  // Blocks new requests until the bridge finishes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      uart_pend_q <= 1'b0;
    end else if (accept && hit.uart) begin
      uart_pend_q <= 1'b1;
    end else if (apb_done_i) begin
      uart_pend_q <= 1'b0;
    end
  end

  assign ready_o     = !uart_pend_q;
  assign l2_sel_o    = sel_q.l2;
  assign ctrl_sel_o  = sel_q.ctrl;
  assign uart_sel_o  = sel_q.uart;
  assign none_sel_o  = sel_q.none;
  assign stage_req_o = stage_req_q;

endmodule

`default_nettype wire

// ==== logic/l2_mem.sv ====
//////////////////////////////
// Word memory, addresses alias every 8 KiB
// Contents survive reset
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module l2_mem import soc_pkg::*; (
  input  wire      clk_i,
  input  wire      rst_i,
  input  wire      sel_i,
  input  bus_req_t req_i,
  output logic     valid_o,
  output bus_rsp_t rsp_o
);

  localparam int unsigned off_w = $clog2(`SOC_DATA_W / 8);

  data_t    mem_q [`SOC_L2_WORDS];
  l2_idx_t  idx;
  logic     valid_q;
  bus_rsp_t rsp_q;

  assign idx = req_i.addr[off_w +: $bits(l2_idx_t)];

  initial begin
    for (int i = 0; i < `SOC_L2_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && req_i.we) begin
      mem_q[idx] <= strb_merge(mem_q[idx], req_i.wdata, req_i.strb);
    end
  end

  // Read data, zero on writes
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rsp_q.rdata <= req_i.we ? '0 : mem_q[idx];
      rsp_q.err   <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sel_i;
    end
  end

  assign valid_o = valid_q;
  assign rsp_o   = rsp_q;

endmodule

`default_nettype wire

// ==== logic/ctrl_regs.sv ====
//////////////////////////////
// Control registers at 64-bit aligned offsets
// Misaligned or unknown offsets answer with an error
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module ctrl_regs import soc_pkg::*; (
  input  wire      clk_i,
  input  wire      rst_i,
  input  wire      sel_i,
  input  bus_req_t req_i,
  output logic     valid_o,
  output bus_rsp_t rsp_o,
  output data_t    exit_o,
  output data_t    hw_cnt_en_o
);

  localparam int unsigned off_w = $clog2(`SOC_CTRL_LEN);

  localparam data_t dram_base = data_t'(`SOC_DRAM_BASE);
  localparam data_t dram_end  = data_t'(`SOC_DRAM_BASE) + data_t'(`SOC_DRAM_LEN);

  logic [off_w-1:0] off;
  data_t            exit_q;
  data_t            cnt_en_q;
  data_t            rd_data;
  logic             bad_off;
  logic             valid_q;
  bus_rsp_t         rsp_q;

  assign off = req_i.addr[off_w-1:0];

  always_comb begin
    rd_data = '0;
    bad_off = 1'b0;
    case (off)
      `SOC_CTRL_EXIT:      rd_data = exit_q;
      `SOC_CTRL_DRAM_BASE: rd_data = dram_base;
      `SOC_CTRL_DRAM_END:  rd_data = dram_end;
      `SOC_CTRL_CNT_EN:    rd_data = cnt_en_q;
      default:             bad_off = 1'b1;
    endcase
  end

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  // DRAM range writes fall through silently
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
    end else if (sel_i && req_i.we) begin
      if (off == `SOC_CTRL_EXIT) begin
        exit_q <= strb_merge(exit_q, req_i.wdata, req_i.strb);
      end
      if (off == `SOC_CTRL_CNT_EN) begin
        cnt_en_q <= strb_merge(cnt_en_q, req_i.wdata, req_i.strb);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rsp_q.rdata <= req_i.we ? '0 : rd_data;
      rsp_q.err   <= bad_off;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sel_i;
    end
  end

  assign valid_o     = valid_q;
  assign rsp_o       = rsp_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

`default_nettype wire

// ==== logic/apb_bridge.sv ====
//////////////////////////////
// APB master for the UART window, one transfer at a time
// Only the low 32 bits go out, byte strobes are dropped
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module apb_bridge import soc_pkg::*; (
  input  wire       clk_i,
  input  wire       rst_i,
  input  wire       sel_i,
  input  bus_req_t  req_i,
  output logic      valid_o,
  output bus_rsp_t  rsp_o,
  output logic      done_o,
  output logic      psel_o,
  output logic      penable_o,
  output logic      pwrite_o,
  output addr_t     paddr_o,
  output apb_data_t pwdata_o,
  input  apb_data_t prdata_i,
  input  wire       pready_i,
  input  wire       pslverr_i
);

  apb_state_e state_q;
  apb_state_e state_d;
  bus_req_t   req_q;
  logic       xfer_end;

  assign xfer_end = (state_q == ACCESS) && pready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (sel_i) state_d = SETUP;
      SETUP:   state_d = ACCESS;
      ACCESS:  if (pready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && sel_i) begin
      req_q <= req_i;
    end
  end

  //////////////////////////////
  // APB and bus outputs
  //////////////////////////////

  assign psel_o    = state_q != IDLE;
  assign penable_o = state_q == ACCESS;
  assign pwrite_o  = req_q.we;
  assign paddr_o   = req_q.addr - addr_t'(`SOC_UART_BASE);
  assign pwdata_o  = req_q.wdata[`SOC_APB_DATA_W-1:0];

  // Result goes straight out in the pready cycle
  assign valid_o     = xfer_end;
  assign done_o      = xfer_end;
  assign rsp_o.rdata = req_q.we ? '0 : data_t'(prdata_i);
  assign rsp_o.err   = pslverr_i;

endmodule

`default_nettype wire

// ==== logic/soc_rsp_stage.sv ====
//////////////////////////////
// Bus response register
// At most one target result may be valid per cycle
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module soc_rsp_stage import soc_pkg::*; (
  input  wire      clk_i,
  input  wire      rst_i,
  input  wire      l2_valid_i,
  input  wire      ctrl_valid_i,
  input  wire      uart_valid_i,
  input  wire      none_sel_i,
  input  bus_rsp_t l2_rsp_i,
  input  bus_rsp_t ctrl_rsp_i,
  input  bus_rsp_t uart_rsp_i,
  output logic     rsp_valid_o,
  output bus_rsp_t rsp_o
);

  logic     none_q;
  logic     any_valid;
  bus_rsp_t rsp_d;
  bus_rsp_t rsp_q;
  logic     rsp_valid_q;

  assign any_valid = l2_valid_i || ctrl_valid_i || uart_valid_i || none_q;

  always_comb begin
    rsp_d = '0;
    if (l2_valid_i) begin
      rsp_d = l2_rsp_i;
    end else if (ctrl_valid_i) begin
      rsp_d = ctrl_rsp_i;
    end else if (uart_valid_i) begin
      rsp_d = uart_rsp_i;
    end else if (none_q) begin
      rsp_d.err = 1'b1;
    end
  end

  // Unmapped gets one extra cycle to line up with L2 and control
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      none_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      none_q      <= none_sel_i;
      rsp_valid_q <= any_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_valid) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// ==== logic/mem_soc.sv ====
//////////////////////////////
// System bus top, one requester and three targets
// Responses cannot be stalled, only ready_o holds requests back
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_soc import soc_pkg::*; (
  input  wire       clk_i,
  input  wire       rst_i,
  input  wire       req_i,
  input  wire       req_we_i,
  input  addr_t     req_addr_i,
  input  data_t     req_wdata_i,
  input  strb_t     req_strb_i,
  output logic      ready_o,
  output logic      rsp_valid_o,
  output data_t     rsp_rdata_o,
  output logic      rsp_err_o,
  output data_t     exit_o,
  output data_t     hw_cnt_en_o,
  output logic      uart_psel_o,
  output logic      uart_penable_o,
  output logic      uart_pwrite_o,
  output addr_t     uart_paddr_o,
  output apb_data_t uart_pwdata_o,
  input  apb_data_t uart_prdata_i,
  input  wire       uart_pready_i,
  input  wire       uart_pslverr_i
);

  bus_req_t in_req;
  bus_req_t stage_req;
  logic     l2_sel;
  logic     ctrl_sel;
  logic     uart_sel;
  logic     none_sel;
  logic     l2_valid;
  logic     ctrl_valid;
  logic     uart_valid;
  logic     apb_done;
  bus_rsp_t l2_rsp;
  bus_rsp_t ctrl_rsp;
  bus_rsp_t uart_rsp;
  bus_rsp_t bus_rsp;

  assign in_req.we    = req_we_i;
  assign in_req.addr  = req_addr_i;
  assign in_req.wdata = req_wdata_i;
  assign in_req.strb  = req_strb_i;

  //////////////////////////////
  // Decode
  //////////////////////////////

  soc_decode_stage i_decode (
    .clk_i       (clk_i    ),
    .rst_i       (rst_i    ),
    .req_valid_i (req_i    ),
    .req_i       (in_req   ),
    .ready_o     (ready_o  ),
    .apb_done_i  (apb_done ),
    .l2_sel_o    (l2_sel   ),
    .ctrl_sel_o  (ctrl_sel ),
    .uart_sel_o  (uart_sel ),
    .none_sel_o  (none_sel ),
    .stage_req_o (stage_req)
  );

  //////////////////////////////
  // Targets
  //////////////////////////////

  l2_mem i_l2 (
    .clk_i   (clk_i    ),
    .rst_i   (rst_i    ),
    .sel_i   (l2_sel   ),
    .req_i   (stage_req),
    .valid_o (l2_valid ),
    .rsp_o   (l2_rsp   )
  );

  ctrl_regs i_ctrl (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .sel_i       (ctrl_sel   ),
    .req_i       (stage_req  ),
    .valid_o     (ctrl_valid ),
    .rsp_o       (ctrl_rsp   ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

  apb_bridge i_uart_apb (
    .clk_i     (clk_i         ),
    .rst_i     (rst_i         ),
    .sel_i     (uart_sel      ),
    .req_i     (stage_req     ),
    .valid_o   (uart_valid    ),
    .rsp_o     (uart_rsp      ),
    .done_o    (apb_done      ),
    .psel_o    (uart_psel_o   ),
    .penable_o (uart_penable_o),
    .pwrite_o  (uart_pwrite_o ),
    .paddr_o   (uart_paddr_o  ),
    .pwdata_o  (uart_pwdata_o ),
    .prdata_i  (uart_prdata_i ),
    .pready_i  (uart_pready_i ),
    .pslverr_i (uart_pslverr_i)
  );

  //////////////////////////////
  // Response
  //////////////////////////////

  soc_rsp_stage i_rsp (
    .clk_i        (clk_i      ),
    .rst_i        (rst_i      ),
    .l2_valid_i   (l2_valid   ),
    .ctrl_valid_i (ctrl_valid ),
    .uart_valid_i (uart_valid ),
    .none_sel_i   (none_sel   ),
    .l2_rsp_i     (l2_rsp     ),
    .ctrl_rsp_i   (ctrl_rsp   ),
    .uart_rsp_i   (uart_rsp   ),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (bus_rsp    )
  );

  assign rsp_rdata_o = bus_rsp.rdata;
  assign rsp_err_o   = bus_rsp.err;

endmodule

`default_nettype wire

// ==== bench/tb_ref_model.svh ====
//////////////////////////////
// Reference model of the memory map, included inside the testbench module
// Shadow state moves when a request is issued, so responses must come back in order
//////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
  addr_t       addr;
  data_t       rdata;
  logic        err;
  logic        is_uart;
  logic [31:0] due;
} exp_t;

data_t     ref_l2 [`SOC_L2_WORDS];
data_t     ref_exit;
data_t     ref_cnt_en;
apb_data_t ref_uart [1024];

// Start contents of the UART word store
function automatic apb_data_t uart_fill(logic [9:0] idx);
  return (apb_data_t'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
endfunction

function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t be);
  data_t mask;
  for (int b = 0; b < 8; b++) begin
    mask[b*8 +: 8] = {8{be[b]}};
  end
  return (old_w & ~mask) | (new_w & mask);
endfunction

task automatic init_ref();
  for (int i = 0; i < `SOC_L2_WORDS; i++) begin
    ref_l2[i] = '0;
  end
  for (int i = 0; i < 1024; i++) begin
    ref_uart[i] = uart_fill(i[9:0]);
  end
  ref_exit   = '0;
  ref_cnt_en = '0;
endtask

function automatic exp_t predict(logic we, addr_t addr, data_t wdata, strb_t strb);
  exp_t        e;
  logic [11:0] off;
  l2_idx_t     idx;
  e    = '0;
  e.addr = addr;
  off  = addr[11:0];
  idx  = addr[12:3];
  if (addr[31:30] == 2'b10) begin
    if (we) begin
      ref_l2[idx] = merge_bytes(ref_l2[idx], wdata, strb);
    end else begin
      e.rdata = ref_l2[idx];
    end
  end else if (addr[31:12] == 20'hC0000) begin
    // Upper half of the UART window answers with pslverr
    e.is_uart = 1'b1;
    if (off >= 12'h800) begin
      e.err = 1'b1;
    end else if (we) begin
      ref_uart[off[11:2]] = wdata[31:0];
    end else begin
      e.rdata = {32'h0, ref_uart[off[11:2]]};
    end
  end else if (addr[31:12] == 20'hD0000) begin
    case (off)
      12'h000: begin
        if (we) ref_exit = merge_bytes(ref_exit, wdata, strb);
        else e.rdata = ref_exit;
      end
      12'h008: if (!we) e.rdata = 64'h0000_0000_8000_0000;
      12'h010: if (!we) e.rdata = 64'h0000_0000_C000_0000;
      12'h018: begin
        if (we) ref_cnt_en = merge_bytes(ref_cnt_en, wdata, strb);
        else e.rdata = ref_cnt_en;
      end
      default: e.err = 1'b1;
    endcase
  end else begin
    e.err = 1'b1;
  end
  return e;
endfunction

`endif

// ==== bench/tb_mem_soc.sv ====
//////////////////////////////
// Testbench for the system bus with an APB model of 0 to 3 wait states
// Upper half of the UART window answers with pslverr
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module tb_mem_soc import soc_pkg::*; ();

  localparam int unsigned rst_cycles = 16;
  localparam int unsigned test_len   = 1 + 32 + 16 + 15 + 24 + 8;
  localparam int unsigned max_cycles = 8 * (test_len + rst_cycles);

  logic      clk;
  logic      rst;
  logic      req;
  logic      req_we;
  addr_t     req_addr;
  data_t     req_wdata;
  strb_t     req_strb;
  logic      ready;
  logic      rsp_valid;
  data_t     rsp_rdata;
  logic      rsp_err;
  data_t     exit_val;
  data_t     cnt_en;
  logic      psel;
  logic      penable;
  logic      pwrite;
  addr_t     paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  `include "tb_ref_model.svh"

  exp_t        exp_q [$];
  apb_data_t   apb_mem [1024];
  addr_t       exp_paddr = '0;
  int unsigned cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          uart_issued = 0;
  int          uart_done = 0;
  int          apb_xfers = 0;

  mem_soc dut_i (
    .clk_i          (clk      ),
    .rst_i          (rst      ),
    .req_i          (req      ),
    .req_we_i       (req_we   ),
    .req_addr_i     (req_addr ),
    .req_wdata_i    (req_wdata),
    .req_strb_i     (req_strb ),
    .ready_o        (ready    ),
    .rsp_valid_o    (rsp_valid),
    .rsp_rdata_o    (rsp_rdata),
    .rsp_err_o      (rsp_err  ),
    .exit_o         (exit_val ),
    .hw_cnt_en_o    (cnt_en   ),
    .uart_psel_o    (psel     ),
    .uart_penable_o (penable  ),
    .uart_pwrite_o  (pwrite   ),
    .uart_paddr_o   (paddr    ),
    .uart_pwdata_o  (pwdata   ),
    .uart_prdata_i  (prdata   ),
    .uart_pready_i  (pready   ),
    .uart_pslverr_i (pslverr  )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc++;
    if (cyc >= max_cycles) begin
      $display("Timeout: the run did not end within %0d cycles", max_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Starts on a falling edge and ends on the one after acceptance
  task automatic issue_req(input logic we, input addr_t addr, input data_t wdata,
                           input strb_t strb);
    exp_t e;
    while (!ready) begin
      @(negedge clk);
    end
    e     = predict(we, addr, wdata, strb);
    e.due = cyc + 4;
    if (e.is_uart) begin
      exp_paddr = {20'd0, addr[11:0]};
    end
    exp_q.push_back(e);
    req       = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    req_strb  = strb;
    @(negedge clk);
    req = 1'b0;
    if (e.is_uart) begin
      uart_issued++;
    end
  endtask

  task automatic write_word(input addr_t addr, input data_t wdata, input strb_t strb);
    issue_req(1'b1, addr, wdata, strb);
  endtask

  task automatic read_word(input addr_t addr);
    issue_req(1'b0, addr, '0, '0);
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    $display("Test %0d %s: %0d errors", tests_run, name, errors - err_start);
  endtask

  function automatic data_t rand_data();
    return {$urandom(), $urandom()};
  endfunction

  // Random upper bits and byte offset keep the same L2 word
  function automatic addr_t l2_addr(l2_idx_t idx, logic aliased);
    addr_t a;
    a = 32'h8000_0000 | {19'd0, idx, 3'd0};
    if (aliased) begin
      a = a | ($urandom() & 32'h3FFF_E007);
    end
    return a;
  endfunction

  function automatic addr_t ctrl_addr(logic [11:0] off);
    return 32'hD000_0000 | {20'd0, off};
  endfunction

  function automatic addr_t uart_addr(logic [11:0] off);
    return 32'hC000_0000 | {20'd0, off};
  endfunction

  //////////////////////////////
  // APB responder
  //////////////////////////////

  initial begin
    int unsigned wait_left;
    logic        in_xfer;
    logic        prev_psel;
    for (int i = 0; i < 1024; i++) begin
      apb_mem[i] = uart_fill(i[9:0]);
    end
    prdata    = '0;
    pready    = 1'b0;
    pslverr   = 1'b0;
    wait_left = 0;
    in_xfer   = 1'b0;
    prev_psel = 1'b0;
    forever begin
      @(negedge clk);
      pready  = 1'b0;
      pslverr = 1'b0;
      prdata  = '0;
      if (!rst && psel && !penable) begin
        apb_xfers++;
        if (prev_psel) begin
          $display("ERROR at %0t: APB SETUP did not follow an idle cycle", $time);
          errors++;
        end
        if (paddr !== exp_paddr) begin
          $display("ERROR at %0t: paddr %h, expected %h", $time, paddr, exp_paddr);
          errors++;
        end
        if (uart_issued == uart_done) begin
          $display("ERROR at %0t: APB select with no UART request open", $time);
          errors++;
        end
      end
      if (!rst && psel && penable) begin
        if (!prev_psel) begin
          $display("ERROR at %0t: APB ACCESS without a SETUP cycle", $time);
          errors++;
        end
        if (!in_xfer) begin
          in_xfer   = 1'b1;
          wait_left = $urandom_range(3, 0);
        end
        if (wait_left == 0) begin
          in_xfer = 1'b0;
          pready  = 1'b1;
          if (paddr >= 32'h800) begin
            pslverr = 1'b1;
          end else if (pwrite) begin
            apb_mem[paddr[11:2]] = pwdata;
          end else begin
            prdata = apb_mem[paddr[11:2]];
          end
        end else begin
          wait_left--;
        end
      end
      prev_psel = psel;
    end
  end

  //////////////////////////////
  // Response checker
  //////////////////////////////

  always @(negedge clk) begin
    exp_t e;
    if (!rst) begin
      if (uart_issued != uart_done && !rsp_valid && ready) begin
        $display("ERROR at %0t: ready_o high while a UART access is open", $time);
        errors++;
      end
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived at %0t with no request outstanding", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          checks++;
          if (rsp_rdata !== e.rdata || rsp_err !== e.err) begin
            $display("ERROR at %0t: addr %h got rdata %h err %b, expected rdata %h err %b",
                     $time, e.addr, rsp_rdata, rsp_err, e.rdata, e.err);
            errors++;
          end
          if (!e.is_uart && cyc != e.due) begin
            $display("ERROR at %0t: addr %h answered in cycle %0d, expected cycle %0d",
                     $time, e.addr, cyc, e.due);
            errors++;
          end
          if (e.is_uart && !ready) begin
            $display("ERROR at %0t: ready_o low on the UART response", $time);
            errors++;
          end
          if (e.is_uart) begin
            uart_done++;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int          err_start;
    l2_idx_t     wr_idx [16];
    logic [11:0] uoff [8];
    void'($urandom(32'h9efa));
    rst       = 1'b1;
    req       = 1'b0;
    req_we    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_strb  = '0;
    init_ref();
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    err_start = errors;
    if (ready !== 1'b1 || rsp_valid !== 1'b0 || psel !== 1'b0 || penable !== 1'b0 ||
        exit_val !== '0 || cnt_en !== '0) begin
      $display("ERROR at %0t: after reset ready %b rsp_valid %b psel %b exit %h cnt_en %h",
               $time, ready, rsp_valid, psel, exit_val, cnt_en);
      errors++;
    end
    report_test("reset values", err_start);

    err_start = errors;
    for (int i = 0; i < 16; i++) begin
      wr_idx[i] = l2_idx_t'($urandom());
      write_word(l2_addr(wr_idx[i], i[0]), rand_data(), strb_t'($urandom()));
    end
    for (int i = 0; i < 16; i++) begin
      read_word(l2_addr(wr_idx[i], 1'b1));
    end
    drain();
    report_test("L2 strobed writes and aliased reads", err_start);

    // Written words hold distinct data, so the order of responses shows
    err_start = errors;
    for (int i = 0; i < 16; i++) begin
      read_word(l2_addr(wr_idx[15 - i], 1'b0));
    end
    drain();
    report_test("L2 back-to-back reads", err_start);

    err_start = errors;
    write_word(ctrl_addr(12'h000), rand_data(), 8'hFF);
    write_word(ctrl_addr(12'h018), rand_data(), strb_t'($urandom()));
    read_word(ctrl_addr(12'h000));
    read_word(ctrl_addr(12'h018));
    read_word(ctrl_addr(12'h008));
    read_word(ctrl_addr(12'h010));
    write_word(ctrl_addr(12'h008), rand_data(), 8'hFF);
    write_word(ctrl_addr(12'h010), rand_data(), 8'hFF);
    read_word(ctrl_addr(12'h008));
    read_word(ctrl_addr(12'h010));
    read_word(ctrl_addr(12'h020));
    write_word(ctrl_addr(12'h004), rand_data(), 8'hFF);
    read_word(ctrl_addr(12'hFF8));
    write_word(ctrl_addr(12'h000), rand_data(), 8'h3C);
    read_word(ctrl_addr(12'h000));
    drain();
    if (exit_val !== ref_exit || cnt_en !== ref_cnt_en) begin
      $display("ERROR at %0t: exit_o %h hw_cnt_en_o %h, expected %h and %h",
               $time, exit_val, cnt_en, ref_exit, ref_cnt_en);
      errors++;
    end
    report_test("control registers", err_start);

    err_start = errors;
    for (int i = 0; i < 8; i++) begin
      uoff[i] = {1'b0, 9'($urandom()), 2'b00};
      write_word(uart_addr(uoff[i]), rand_data(), strb_t'($urandom()));
    end
    for (int i = 0; i < 8; i++) begin
      read_word(uart_addr(uoff[i]));
    end
    for (int i = 0; i < 4; i++) begin
      read_word(uart_addr({1'b0, 9'($urandom()), 2'b00}));
    end
    for (int i = 0; i < 2; i++) begin
      write_word(uart_addr({1'b1, 9'($urandom()), 2'b00}), rand_data(), 8'hFF);
      read_word(uart_addr({1'b1, 9'($urandom()), 2'b00}));
    end
    drain();
    if (apb_xfers != uart_issued) begin
      $display("The APB side saw %0d transfers for %0d UART requests", apb_xfers, uart_issued);
      errors++;
    end
    report_test("UART over APB", err_start);

    err_start = errors;
    read_word(32'h0000_0000);
    write_word(32'h7FFF_FFF8, rand_data(), 8'hFF);
    read_word(32'hC000_1000);
    write_word(32'hCFFF_FFF8, rand_data(), 8'hFF);
    read_word(32'hD000_1000);
    write_word(32'hE000_0000, rand_data(), 8'hFF);
    read_word(32'hFFFF_FFF8);
    read_word(32'h4000_0040);
    drain();
    report_test("unmapped addresses", err_start);

    $display("Summary: %0d tests, %0d responses checked, %0d errors",
             tests_run, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
+incdir+bench
logic/soc_pkg.sv
logic/soc_decode_stage.sv
logic/l2_mem.sv
logic/ctrl_regs.sv
logic/apb_bridge.sv
logic/soc_rsp_stage.sv
logic/mem_soc.sv
bench/tb_mem_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the bus testbench with Verilator, runs it and checks the log

set -u

root="$(cd "$(dirname "${BASH_SOURCE[0]}")" && pwd)"
cd "$root" || exit 1

build_dir="obj_dir"
sim_bin="sim_mem_soc"
log_file="sim.log"

verilator --binary --timing -f build.f --top-module tb_mem_soc \
  -Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Done: errors found" "$log_file"; then
  exit 1
fi
if ! grep -q "Done: no errors" "$log_file"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
